// ==== logic/jsp_consts.svh ====
// JTAG serial port constants
// Byte FIFO sizing, APB address width, 16550 register map and fixed MSR
`ifndef JSP_CONSTS_SVH
`define JSP_CONSTS_SVH

// Byte FIFO sizing
`define JSP_FIFO_DEPTH 8
`define JSP_CNT_W      4

// APB address width
`define JSP_ADDR_W     3

// 16550 register map
// FCR is written at the IIR address
`define JSP_REG_RBR    3'd0
`define JSP_REG_IER    3'd1
`define JSP_REG_IIR    3'd2
`define JSP_REG_LCR    3'd3
`define JSP_REG_MCR    3'd4
`define JSP_REG_LSR    3'd5
`define JSP_REG_MSR    3'd6
`define JSP_REG_SCR    3'd7

// Modem status as seen by software
`define JSP_MSR_VALUE  8'h0b

`endif

// ==== logic/jsp_pkg.sv ====
// JTAG serial port types
// APB request, IER and LCR layouts, FIFO control and status, link events
`default_nettype none
`include "jsp_consts.svh"

package jsp_pkg;

  // APB request seen by the slave
  typedef struct packed {
    logic                   sel;
    logic                   enable;
    logic                   write;
    logic [`JSP_ADDR_W-1:0] addr;
    logic [7:0]             wdata;
  } apb_req_t;

  // Interrupt enable register
  typedef struct packed {
    logic [1:0] unused;
    logic       etbei;
    logic       erbfi;
  } ier_t;

  // Line control register
  typedef struct packed {
    logic       dlab;
    logic       brk;
    logic       stick;
    logic       eps;
    logic       pen;
    logic       stb;
    logic [1:0] wls;
  } lcr_t;

  // FIFO command
  // push low means pop
  typedef struct packed {
    logic enable;
    logic push;
  } fifo_ctl_t;

  // FIFO occupancy
  typedef struct packed {
    logic [`JSP_CNT_W-1:0] avail;
    logic [`JSP_CNT_W-1:0] free;
  } fifo_stat_t;

  // Debug-side events in PCLK
  typedef struct packed {
    logic wdata_avail;
    logic pop_req;
    logic link_up;
  } link_evt_t;

endpackage

`default_nettype wire

// ==== logic/jsp_toggle_sync.sv ====
// Toggle-to-level strobe synchronizer
// An edge of toggle_i sets level_o in dest_clk_i, clr_i drops it
`timescale 1ns/1ps
`default_nettype none

module jsp_toggle_sync (
  input  wire  dest_clk_i,
  input  wire  rst_i,
  input  wire  toggle_i,
  input  wire  clr_i,
  output logic level_o
);

  // Two sync stages plus a delayed copy
  logic sync1_q;
  logic sync2_q;
  logic sync3_q;
  logic edge_seen;

  always_ff @(posedge dest_clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      sync1_q <= 1'b0;
      sync2_q <= 1'b0;
      sync3_q <= 1'b0;
    end
    else
    begin
      sync1_q <= toggle_i;
      sync2_q <= sync1_q;
      sync3_q <= sync2_q;
    end
  end

  // Either direction of the toggle is one event
  assign edge_seen = sync2_q ^ sync3_q;

  // New event beats a clear in the same cycle
  always_ff @(posedge dest_clk_i or posedge rst_i)
  begin
    if (rst_i)
      level_o <= 1'b0;
    else if (edge_seen)
      level_o <= 1'b1;
    else if (clr_i)
      level_o <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== logic/jsp_count_sync.sv ====
// Byte count crossing from PCLK into tck_i
// Source holding register and a req/ack toggle pair
`timescale 1ns/1ps
`default_nettype none
`include "jsp_consts.svh"

module jsp_count_sync (
  input  wire                   PCLK,
  input  wire                   rst_i,
  input  wire                   tck_i,
  input  wire  [`JSP_CNT_W-1:0] count_i,
  output logic [`JSP_CNT_W-1:0] count_o
);

  logic [`JSP_CNT_W-1:0] src_q;
  logic                  req_q;
  logic                  ack_meta_q;
  logic                  ack_sync_q;
  logic                  req_meta_q;
  logic                  req_sync_q;
  logic                  ack_q;
  logic                  idle;

  // Source side is free once ack has come back
  assign idle = (req_q == ack_sync_q);

  // Source copy held stable while a request is open
  always_ff @(posedge PCLK)
  begin
    if (idle)
      src_q <= count_i;
  end

  always_ff @(posedge PCLK or posedge rst_i)
  begin
    if (rst_i)
    begin
      req_q      <= 1'b0;
      ack_meta_q <= 1'b0;
      ack_sync_q <= 1'b0;
    end
    else
    begin
      ack_meta_q <= ack_q;
      ack_sync_q <= ack_meta_q;
      if (idle)
        req_q <= ~req_q;
    end
  end

  // tck_i side
  // takes the copy when a new request shows up
  always_ff @(posedge tck_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      req_meta_q <= 1'b0;
      req_sync_q <= 1'b0;
      ack_q      <= 1'b0;
      count_o    <= '0;
    end
    else
    begin
      req_meta_q <= req_q;
      req_sync_q <= req_meta_q;
      if (req_sync_q != ack_q)
      begin
        count_o <= src_q;
        ack_q   <= req_sync_q;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/jsp_byte_fifo.sv ====
// Eight-byte circular FIFO in PCLK
// Shared push/pop enable, occupancy status, head byte always visible
`timescale 1ns/1ps
`default_nettype none
`include "jsp_consts.svh"

module jsp_byte_fifo (
  input  wire                 PCLK,
  input  wire                 clr_i,
  input  wire  [7:0]          data_i,
  input  wire  jsp_pkg::fifo_ctl_t  ctl_i,
  output logic [7:0]          data_o,
  output jsp_pkg::fifo_stat_t stat_o
);

  localparam int PTR_W = $clog2(`JSP_FIFO_DEPTH);
  localparam logic [`JSP_CNT_W-1:0] FULL = `JSP_FIFO_DEPTH;

  logic [7:0]            mem [`JSP_FIFO_DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [`JSP_CNT_W-1:0] count;
  logic                  do_push;
  logic                  do_pop;

  // Push when full and pop when empty are dropped
  assign do_push = ctl_i.enable & ctl_i.push & (count != FULL);
  assign do_pop  = ctl_i.enable & ~ctl_i.push & (count != '0);

  // Storage
  always_ff @(posedge PCLK)
  begin
    if (do_push)
      mem[wr_ptr] <= data_i;
  end

  // Pointers wrap on their own at a power-of-two depth
  always_ff @(posedge PCLK or posedge clr_i)
  begin
    if (clr_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
        count  <= count + 1'b1;
      end
      else if (do_pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
        count  <= count - 1'b1;
      end
    end
  end

  assign data_o       = mem[rd_ptr];
  assign stat_o.avail = count;
  assign stat_o.free  = FULL - count;

endmodule

`default_nettype wire

// ==== logic/jsp_jtag_port.sv ====
// Debug-side byte port
// Write data capture, strobe toggles, link flop and their PCLK synchronizers
`timescale 1ns/1ps
`default_nettype none

module jsp_jtag_port (
  input  wire                tck_i,
  input  wire                rst_i,
  input  wire                PCLK,
  input  wire  [7:0]         data_i,
  input  wire                wr_strobe_i,
  input  wire                rd_strobe_i,
  input  wire                wdata_clr_i,
  input  wire                pop_clr_i,
  output logic [7:0]         wdata_o,
  output jsp_pkg::link_evt_t evt_o
);

  logic wen_tgl_q;
  logic ren_tgl_q;
  logic link_q;
  logic wdata_avail;
  logic pop_req;
  logic link_up;

  ////////////////////////////////
  // tck_i domain
  ////////////////////////////////

  // Drops with rst_i, rises on the first tck_i edge after
  always_ff @(posedge tck_i or posedge rst_i)
  begin
    if (rst_i)
      link_q <= 1'b0;
    else
      link_q <= 1'b1;
  end

  // One flip per strobe
  always_ff @(posedge tck_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wen_tgl_q <= 1'b0;
      ren_tgl_q <= 1'b0;
    end
    else
    begin
      if (wr_strobe_i)
        wen_tgl_q <= ~wen_tgl_q;
      if (rd_strobe_i)
        ren_tgl_q <= ~ren_tgl_q;
    end
  end

  // Byte held here until PCLK pushes it
  always_ff @(posedge tck_i)
  begin
    if (wr_strobe_i)
      wdata_o <= data_i;
  end

  ////////////////////////////////
  // Crossings into PCLK
  ////////////////////////////////

  jsp_toggle_sync u_wen_sync (
    .dest_clk_i (PCLK),
    .rst_i      (rst_i),
    .toggle_i   (wen_tgl_q),
    .clr_i      (wdata_clr_i),
    .level_o    (wdata_avail)
  );

  jsp_toggle_sync u_ren_sync (
    .dest_clk_i (PCLK),
    .rst_i      (rst_i),
    .toggle_i   (ren_tgl_q),
    .clr_i      (pop_clr_i),
    .level_o    (pop_req)
  );

  // Link level never clears once up
  jsp_toggle_sync u_link_sync (
    .dest_clk_i (PCLK),
    .rst_i      (rst_i),
    .toggle_i   (link_q),
    .clr_i      (1'b0),
    .level_o    (link_up)
  );

  assign evt_o = '{wdata_avail: wdata_avail, pop_req: pop_req, link_up: link_up};

endmodule

`default_nettype wire

// ==== logic/jsp_xfer_fsm.sv ====
// Transfer sequencers in PCLK
// RX side moves debug bytes in and RBR reads out
// TX side moves THR writes in and debug pops out, with the data_o latch
`timescale 1ns/1ps
`default_nettype none
`include "jsp_consts.svh"

module jsp_xfer_fsm (
  input  wire                 PCLK,
  input  wire                 PRESETn,
  input  wire                 rbr_rd_i,
  input  wire                 thr_wr_i,
  input  wire  jsp_pkg::link_evt_t  evt_i,
  input  wire  jsp_pkg::fifo_stat_t tx_stat_i,
  output jsp_pkg::fifo_ctl_t  rx_ctl_o,
  output jsp_pkg::fifo_ctl_t  tx_ctl_o,
  output logic                wdata_clr_o,
  output logic                pop_clr_o,
  output logic                latch_o,
  output logic                tx_pop_o,
  output logic                ack_o
);

  localparam logic [`JSP_CNT_W-1:0] ONE = 1;

  typedef enum logic [1:0] {RX_IDLE, RX_PUSH, RX_POP} rx_state_e;
  typedef enum logic [1:0] {TX_IDLE, TX_PUSH, TX_POP, TX_LATCH} tx_state_e;

  rx_state_e rx_state;
  rx_state_e rx_next;
  tx_state_e tx_state;
  tx_state_e tx_next;
  logic      tx_pop_ok;

  // Debug pop only when there is a byte to give
  assign tx_pop_ok = evt_i.pop_req & (tx_stat_i.avail != '0);

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      rx_state <= RX_IDLE;
      tx_state <= TX_IDLE;
    end
    else
    begin
      rx_state <= rx_next;
      tx_state <= tx_next;
    end
  end

  ////////////////////////////////
  // RX sequencer
  ////////////////////////////////

  // RBR read first, it must ack in the access cycle
  always_comb
  begin
    case (rx_state)
      RX_IDLE: rx_next = rbr_rd_i ? RX_POP : (evt_i.wdata_avail ? RX_PUSH : RX_IDLE);
      RX_PUSH: rx_next = rbr_rd_i ? RX_POP : RX_IDLE;
      RX_POP:  rx_next = evt_i.wdata_avail ? RX_PUSH : RX_IDLE;
      default: rx_next = RX_IDLE;
    endcase
  end

  assign rx_ctl_o.enable = (rx_state == RX_PUSH) | (rx_state == RX_POP);
  assign rx_ctl_o.push   = (rx_state == RX_PUSH);
  assign wdata_clr_o     = (rx_state == RX_PUSH);

  ////////////////////////////////
  // TX sequencer
  ////////////////////////////////

  // Every push and pop ends in a latch of the head byte
  // covers the first byte into an empty FIFO too
  always_comb
  begin
    case (tx_state)
      TX_IDLE,
      TX_LATCH: tx_next = thr_wr_i ? TX_PUSH : (tx_pop_ok ? TX_POP : TX_IDLE);
      TX_PUSH:  tx_next = tx_pop_ok ? TX_POP : TX_LATCH;
      TX_POP:   tx_next = thr_wr_i ? TX_PUSH : TX_LATCH;
      default:  tx_next = TX_IDLE;
    endcase
  end

  assign tx_ctl_o.enable = (tx_state == TX_PUSH) | (tx_state == TX_POP);
  assign tx_ctl_o.push   = (tx_state == TX_PUSH);
  assign pop_clr_o       = (tx_state == TX_POP);
  assign latch_o         = (tx_state == TX_LATCH);

  // Last byte leaving the TX FIFO
  assign tx_pop_o = (tx_state == TX_POP) & (tx_stat_i.avail == ONE);

  // FIFO access acknowledge
  assign ack_o = (rx_state == RX_POP) | (tx_state == TX_PUSH);

endmodule

`default_nettype wire

// ==== logic/jsp_apb_regs.sv ====
// 16550-style APB register block
// IER, LCR and SCR, FIFO strobes and FCR clears
// LSR, IIR with THR interrupt arm, read mux, PREADY and int_o
`timescale 1ns/1ps
`default_nettype none
`include "jsp_consts.svh"

module jsp_apb_regs (
  input  wire                 PCLK,
  input  wire                 PRESETn,
  input  wire  jsp_pkg::apb_req_t   req_i,
  input  wire  [7:0]          rx_head_i,
  input  wire  jsp_pkg::fifo_stat_t rx_stat_i,
  input  wire  jsp_pkg::fifo_stat_t tx_stat_i,
  input  wire                 link_up_i,
  input  wire                 tx_pop_i,
  input  wire                 fifo_ack_i,
  output logic                rbr_rd_o,
  output logic                thr_wr_o,
  output logic                rx_clr_o,
  output logic                tx_clr_o,
  output logic [7:0]          prdata_o,
  output logic                pready_o,
  output logic                int_o
);

  jsp_pkg::ier_t ier;
  jsp_pkg::lcr_t lcr;
  logic [7:0]    scr;
  logic [7:0]    iir;
  logic [7:0]    lsr;
  logic          reg_ack;
  logic          thr_arm;
  logic          setup;
  logic          access;
  logic          fifo_sel;
  logic          fcr_wr;
  logic          iir_rd;
  logic          rx_ready;
  logic          tx_ready;

  ////////////////////////////////
  // Bus decode
  ////////////////////////////////

  assign setup    = req_i.sel & ~req_i.enable;
  assign access   = req_i.sel & req_i.enable;
  // DLAB hides the FIFOs
  assign fifo_sel = (req_i.addr == `JSP_REG_RBR) & ~lcr.dlab;

  // FIFO strobes go out in setup so the sequencer acks in access
  assign rbr_rd_o = setup & ~req_i.write & fifo_sel;
  assign thr_wr_o = setup & req_i.write & fifo_sel;

  assign fcr_wr   = access & req_i.write & (req_i.addr == `JSP_REG_IIR);
  assign iir_rd   = access & ~req_i.write & (req_i.addr == `JSP_REG_IIR);
  assign rx_clr_o = fcr_wr & req_i.wdata[1];
  assign tx_clr_o = fcr_wr & req_i.wdata[2];

  // Plain registers ack one cycle after setup
  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
      reg_ack <= 1'b0;
    else
      reg_ack <= setup & ~fifo_sel;
  end

  assign pready_o = fifo_ack_i | reg_ack;

  ////////////////////////////////
  // Writable registers
  ////////////////////////////////

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      ier <= '0;
      lcr <= '0;
      scr <= '0;
    end
    else if (access & req_i.write)
    begin
      case (req_i.addr)
        `JSP_REG_IER: if (!lcr.dlab) ier <= req_i.wdata[3:0];
        `JSP_REG_LCR: lcr <= req_i.wdata;
        `JSP_REG_SCR: scr <= req_i.wdata;
        default: ;
      endcase
    end
  end

  ////////////////////////////////
  // Status and interrupt
  ////////////////////////////////

  assign rx_ready = (rx_stat_i.avail != '0);
  // THR writes held off until the debug link is up
  assign tx_ready = (tx_stat_i.avail != `JSP_FIFO_DEPTH) & link_up_i;
  assign lsr      = {1'b0, tx_ready, tx_ready, 4'h0, rx_ready};

  // Armed by a THR write or the TX FIFO running dry
  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
      thr_arm <= 1'b0;
    else if (thr_wr_o | tx_pop_i)
      thr_arm <= 1'b1;
    else if (iir_rd & ~rx_ready)
      thr_arm <= 1'b0;
  end

  // RX data outranks THR empty
  always_comb
  begin
    if (rx_ready)
      iir = 8'h04;
    else if (thr_arm & tx_ready)
      iir = 8'h02;
    else
      iir = 8'h01;
  end

  assign int_o = (tx_ready & thr_arm & ier.etbei) | (rx_ready & ier.erbfi);

  // Read mux
  always_comb
  begin
    case (req_i.addr)
      `JSP_REG_RBR: prdata_o = rx_head_i;
      `JSP_REG_IER: prdata_o = {4'h0, ier};
      `JSP_REG_IIR: prdata_o = iir;
      `JSP_REG_LCR: prdata_o = lcr;
      `JSP_REG_MCR: prdata_o = 8'h00;
      `JSP_REG_LSR: prdata_o = lsr;
      `JSP_REG_MSR: prdata_o = `JSP_MSR_VALUE;
      default:      prdata_o = scr;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/jsp_apb_biu.sv ====
// JTAG serial port APB bus interface unit
// Debug port, RX and TX byte FIFOs, sequencers, 16550 registers
// Count synchronizers toward tck_i and the data_o latch
`timescale 1ns/1ps
`default_nettype none
`include "jsp_consts.svh"

module jsp_apb_biu (
  input  wire                   PCLK,
  input  wire                   PRESETn,
  input  wire                   tck_i,
  input  wire                   rst_i,
  input  wire  [7:0]            data_i,
  output logic [7:0]            data_o,
  output logic [`JSP_CNT_W-1:0] bytes_available_o,
  output logic [`JSP_CNT_W-1:0] bytes_free_o,
  input  wire                   rd_strobe_i,
  input  wire                   wr_strobe_i,
  input  wire                   psel_i,
  input  wire                   penable_i,
  input  wire                   pwrite_i,
  input  wire  [`JSP_ADDR_W-1:0] paddr_i,
  input  wire  [7:0]            pwdata_i,
  output logic [7:0]            prdata_o,
  output logic                  pready_o,
  output logic                  int_o
);

  jsp_pkg::apb_req_t   req;
  jsp_pkg::link_evt_t  evt;
  jsp_pkg::fifo_ctl_t  rx_ctl;
  jsp_pkg::fifo_ctl_t  tx_ctl;
  jsp_pkg::fifo_stat_t rx_stat;
  jsp_pkg::fifo_stat_t tx_stat;
  logic [7:0]          rx_wdata;
  logic [7:0]          rx_head;
  logic [7:0]          tx_head;
  logic                wdata_clr;
  logic                pop_clr;
  logic                latch;
  logic                tx_pop;
  logic                fifo_ack;
  logic                rbr_rd;
  logic                thr_wr;
  logic                rx_clr;
  logic                tx_clr;

  assign req = '{sel: psel_i, enable: penable_i, write: pwrite_i,
                 addr: paddr_i, wdata: pwdata_i};

  jsp_jtag_port u_port (
    .tck_i       (tck_i),
    .rst_i       (rst_i),
    .PCLK        (PCLK),
    .data_i      (data_i),
    .wr_strobe_i (wr_strobe_i),
    .rd_strobe_i (rd_strobe_i),
    .wdata_clr_i (wdata_clr),
    .pop_clr_i   (pop_clr),
    .wdata_o     (rx_wdata),
    .evt_o       (evt)
  );

  ////////////////////////////////
  // Byte FIFOs
  ////////////////////////////////

  // Debug reset or FCR clear empties a FIFO at once
  jsp_byte_fifo u_rx_fifo (
    .PCLK   (PCLK),
    .clr_i  (rst_i | rx_clr),
    .data_i (rx_wdata),
    .ctl_i  (rx_ctl),
    .data_o (rx_head),
    .stat_o (rx_stat)
  );

  jsp_byte_fifo u_tx_fifo (
    .PCLK   (PCLK),
    .clr_i  (rst_i | tx_clr),
    .data_i (req.wdata),
    .ctl_i  (tx_ctl),
    .data_o (tx_head),
    .stat_o (tx_stat)
  );

  jsp_xfer_fsm u_fsm (
    .PCLK        (PCLK),
    .PRESETn     (PRESETn),
    .rbr_rd_i    (rbr_rd),
    .thr_wr_i    (thr_wr),
    .evt_i       (evt),
    .tx_stat_i   (tx_stat),
    .rx_ctl_o    (rx_ctl),
    .tx_ctl_o    (tx_ctl),
    .wdata_clr_o (wdata_clr),
    .pop_clr_o   (pop_clr),
    .latch_o     (latch),
    .tx_pop_o    (tx_pop),
    .ack_o       (fifo_ack)
  );

  jsp_apb_regs u_regs (
    .PCLK       (PCLK),
    .PRESETn    (PRESETn),
    .req_i      (req),
    .rx_head_i  (rx_head),
    .rx_stat_i  (rx_stat),
    .tx_stat_i  (tx_stat),
    .link_up_i  (evt.link_up),
    .tx_pop_i   (tx_pop),
    .fifo_ack_i (fifo_ack),
    .rbr_rd_o   (rbr_rd),
    .thr_wr_o   (thr_wr),
    .rx_clr_o   (rx_clr),
    .tx_clr_o   (tx_clr),
    .prdata_o   (prdata_o),
    .pready_o   (pready_o),
    .int_o      (int_o)
  );

  ////////////////////////////////
  // Toward the debug side
  ////////////////////////////////

  // TX head byte shown to the debug side
  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
      data_o <= '0;
    else if (latch)
      data_o <= tx_head;
  end

  jsp_count_sync u_free_sync (
    .PCLK    (PCLK),
    .rst_i   (rst_i),
    .tck_i   (tck_i),
    .count_i (rx_stat.free),
    .count_o (bytes_free_o)
  );

  jsp_count_sync u_avail_sync (
    .PCLK    (PCLK),
    .rst_i   (rst_i),
    .tck_i   (tck_i),
    .count_i (tx_stat.avail),
    .count_o (bytes_available_o)
  );

endmodule

`default_nettype wire

// ==== tests/jsp_checker.sv ====
// Checker for the JTAG serial port
// Model queues, register shadows, reference read function
// Compares every APB access and every debug-side pop
`timescale 1ns/1ps
`default_nettype none
`include "jsp_consts.svh"

module jsp_checker (
  input wire                   PCLK,
  input wire                   tck_i,
  input wire                   poll_i,
  input wire                   psel_i,
  input wire                   penable_i,
  input wire                   pwrite_i,
  input wire [`JSP_ADDR_W-1:0] paddr_i,
  input wire [7:0]             pwdata_i,
  input wire [7:0]             prdata_i,
  input wire                   pready_i,
  input wire                   int_i,
  input wire [7:0]             data_i,
  input wire                   wr_strobe_i,
  input wire                   rd_strobe_i,
  input wire [7:0]             tx_data_i
);

  logic [7:0] rx_q[$];
  logic [7:0] tx_q[$];
  logic [3:0] ier_s;
  logic [7:0] lcr_s;
  logic [7:0] scr_s;
  logic       arm;
  int         errors;
  int         checks;

  initial
  begin
    ier_s  = '0;
    lcr_s  = '0;
    scr_s  = '0;
    arm    = 1'b0;
    errors = 0;
    checks = 0;
  end

  task automatic note_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic compare(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error: %s got %h expected %h", name, got, exp);
    end
  endtask

  ////////////////////////////////
  // Reference model
  ////////////////////////////////

  function automatic logic tx_ready();
    return tx_q.size() < `JSP_FIFO_DEPTH;
  endfunction

  // Expected int_o from the shadows
  function automatic logic ref_int();
    return (tx_ready() & arm & ier_s[1]) | ((rx_q.size() != 0) & ier_s[0]);
  endfunction

  // Expected prdata_o for a read at addr
  function automatic logic [7:0] ref_read(input logic [`JSP_ADDR_W-1:0] addr);
    logic rxr;
    logic txr;
    rxr = (rx_q.size() != 0);
    txr = tx_ready();
    case (addr)
      `JSP_REG_RBR: return rx_q[0];
      `JSP_REG_IER: return {4'h0, ier_s};
      `JSP_REG_IIR: return rxr ? 8'h04 : ((arm & txr) ? 8'h02 : 8'h01);
      `JSP_REG_LCR: return lcr_s;
      `JSP_REG_MCR: return 8'h00;
      `JSP_REG_LSR: return {1'b0, txr, txr, 4'h0, rxr};
      `JSP_REG_MSR: return 8'h0b;
      default:      return scr_s;
    endcase
  endfunction

  ////////////////////////////////
  // APB side
  ////////////////////////////////

  // Sampled mid-cycle of the access phase
  always @(negedge PCLK)
  begin
    if (psel_i && penable_i)
    begin
      checks++;
      if (!pready_i)
        note_failure("pready_o was low in the first access cycle");
      // Status polls are not settled yet
      if (!pwrite_i && !poll_i)
      begin
        if (!(paddr_i == `JSP_REG_RBR && rx_q.size() == 0))
          compare("prdata_o", prdata_i, ref_read(paddr_i));
        compare("int_o", {7'h0, int_i}, {7'h0, ref_int()});
      end
      if (pwrite_i)
      begin
        case (paddr_i)
          `JSP_REG_RBR:
            if (!lcr_s[7])
            begin
              arm = 1'b1;
              if (tx_q.size() < `JSP_FIFO_DEPTH)
                tx_q.push_back(pwdata_i);
            end
          `JSP_REG_IER: if (!lcr_s[7]) ier_s = pwdata_i[3:0];
          `JSP_REG_IIR:
          begin
            if (pwdata_i[1])
              rx_q.delete();
            if (pwdata_i[2])
              tx_q.delete();
          end
          `JSP_REG_LCR: lcr_s = pwdata_i;
          `JSP_REG_SCR: scr_s = pwdata_i;
          default: ;
        endcase
      end
      else if (paddr_i == `JSP_REG_RBR && !lcr_s[7] && rx_q.size() != 0)
        void'(rx_q.pop_front());
      else if (paddr_i == `JSP_REG_IIR && rx_q.size() == 0)
        arm = 1'b0;
    end
  end

  ////////////////////////////////
  // Debug side
  ////////////////////////////////

  always @(posedge tck_i)
  begin
    if (wr_strobe_i)
      rx_q.push_back(data_i);
    if (rd_strobe_i)
    begin
      if (tx_q.size() == 0)
        note_failure("debug side popped while the TX FIFO was empty");
      else
      begin
        compare("data_o", tx_data_i, tx_q.pop_front());
        // Last byte out arms the THR interrupt
        if (tx_q.size() == 0)
          arm = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/jsp_tb.sv ====
// Testbench for the JTAG serial port APB unit
// Clocks, resets, APB and debug-side tasks, test sequence, watchdog
`timescale 1ns/1ps
`default_nettype none
`include "jsp_consts.svh"

module jsp_tb;

  localparam int PCLK_NS   = 4;
  // Rough length of all tests in PCLK cycles
  localparam int RUN_CYCLES = 2500;

  logic PCLK;
  logic PRESETn;
  logic tck_i;
  logic rst_i;
  logic [7:0] data_i;
  logic [7:0] data_o;
  logic [`JSP_CNT_W-1:0] bytes_available;
  logic [`JSP_CNT_W-1:0] bytes_free;
  logic rd_strobe;
  logic wr_strobe;
  logic psel;
  logic penable;
  logic pwrite;
  logic [`JSP_ADDR_W-1:0] paddr;
  logic [7:0] pwdata;
  logic [7:0] prdata;
  logic pready;
  logic int_o;
  logic poll;
  logic [7:0] rd;
  int   test_num;
  int   tests_failed;
  int   errs_before;

  jsp_apb_biu dut0 (
    .PCLK (PCLK), .PRESETn (PRESETn), .tck_i (tck_i), .rst_i (rst_i),
    .data_i (data_i), .data_o (data_o), .bytes_available_o (bytes_available),
    .bytes_free_o (bytes_free), .rd_strobe_i (rd_strobe), .wr_strobe_i (wr_strobe),
    .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite), .paddr_i (paddr),
    .pwdata_i (pwdata), .prdata_o (prdata), .pready_o (pready), .int_o (int_o)
  );

  jsp_checker chk0 (
    .PCLK (PCLK), .tck_i (tck_i), .poll_i (poll), .psel_i (psel),
    .penable_i (penable), .pwrite_i (pwrite), .paddr_i (paddr), .pwdata_i (pwdata),
    .prdata_i (prdata), .pready_i (pready), .int_i (int_o), .data_i (data_i),
    .wr_strobe_i (wr_strobe), .rd_strobe_i (rd_strobe), .tx_data_i (data_o)
  );

  always #(PCLK_NS / 2.0) PCLK = ~PCLK;
  always #5 tck_i = ~tck_i;

  ////////////////////////////////
  // APB tasks
  ////////////////////////////////

  // Setup cycle, access cycle, then idle
  task automatic apb_xfer(input logic wr, input logic [2:0] addr, input logic [7:0] wd,
                          output logic [7:0] rdata);
    @(posedge PCLK);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wd;
    @(posedge PCLK);
    #1;
    penable = 1'b1;
    @(negedge PCLK);
    rdata = prdata;
    @(posedge PCLK);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [2:0] addr, input logic [7:0] wd);
    logic [7:0] unused;
    apb_xfer(1'b1, addr, wd, unused);
  endtask

  // Repeats LSR reads until one bit reaches a level
  task automatic wait_lsr_bit(input int bit_idx, input logic level);
    logic [7:0] v;
    int         tries;
    tries = 0;
    poll  = 1'b1;
    apb_xfer(1'b0, `JSP_REG_LSR, 8'h00, v);
    while (v[bit_idx] !== level && tries < 200)
    begin
      apb_xfer(1'b0, `JSP_REG_LSR, 8'h00, v);
      tries++;
    end
    poll = 1'b0;
    if (v[bit_idx] !== level)
      chk0.note_failure($sformatf("LSR bit %0d never reached %0d", bit_idx, level));
  endtask

  ////////////////////////////////
  // Debug-side tasks
  ////////////////////////////////

  // Gap after each byte lets PCLK push it before the next capture
  task automatic debug_write(input logic [7:0] b);
    int waits;
    waits = 0;
    while (bytes_free == 0 && waits < 200)
    begin
      @(posedge tck_i);
      waits++;
    end
    if (bytes_free == 0)
      chk0.note_failure("bytes_free_o stayed at zero");
    @(posedge tck_i);
    #1;
    data_i    = b;
    wr_strobe = 1'b1;
    @(posedge tck_i);
    #1;
    wr_strobe = 1'b0;
    repeat (4) @(posedge tck_i);
  endtask

  // Pop one byte, then wait until the count moves
  task automatic debug_read();
    logic [`JSP_CNT_W-1:0] prev;
    int                    waits;
    waits = 0;
    while (bytes_available == 0 && waits < 200)
    begin
      @(posedge tck_i);
      waits++;
    end
    prev = bytes_available;
    @(posedge tck_i);
    #1;
    rd_strobe = 1'b1;
    @(posedge tck_i);
    #1;
    rd_strobe = 1'b0;
    waits = 0;
    while (bytes_available == prev && waits < 200)
    begin
      @(posedge tck_i);
      waits++;
    end
    if (bytes_available == prev)
      chk0.note_failure("bytes_available_o did not change after a debug pop");
  endtask

  // Free count crosses into tck_i late, so let it settle before comparing
  task automatic check_free(input logic [`JSP_CNT_W-1:0] exp);
    int waits;
    waits = 0;
    @(negedge tck_i);
    while (bytes_free !== exp && waits < 200)
    begin
      @(negedge tck_i);
      waits++;
    end
    chk0.compare("bytes_free_o", 8'(bytes_free), 8'(exp));
  endtask

  task automatic start_test();
    test_num++;
    errs_before = chk0.errors;
  endtask

  task automatic end_test(input string name);
    if (chk0.errors == errs_before)
      $display("test %0d %s: ok", test_num, name);
    else
    begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", test_num, name,
               chk0.errors - errs_before);
    end
  endtask

  ////////////////////////////////
  // Watchdog
  ////////////////////////////////

  initial
  begin
    #(RUN_CYCLES * 20 * PCLK_NS);
    $display("watchdog expired before the tests finished");
    $display("** FAIL **");
    $finish;
  end

  initial
  begin
    void'($urandom(32'h8f5cf9ec));
    PCLK = 1'b0;
    tck_i = 1'b0;
    PRESETn = 1'b0;
    rst_i = 1'b1;
    data_i = '0;
    rd_strobe = 1'b0;
    wr_strobe = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    poll = 1'b0;
    test_num = 0;
    tests_failed = 0;
    repeat (3) @(posedge PCLK);
    #1;
    PRESETn = 1'b1;
    rst_i = 1'b0;
    // Link flop has to cross into PCLK
    repeat (20) @(posedge PCLK);

    start_test();
    for (int a = 1; a < 8; a++)
      apb_xfer(1'b0, a[2:0], 8'h00, rd);
    end_test("reset values");

    start_test();
    repeat (4)
    begin
      apb_write(`JSP_REG_SCR, 8'($urandom));
      apb_xfer(1'b0, `JSP_REG_SCR, 8'h00, rd);
      apb_write(`JSP_REG_LCR, 8'($urandom));
      apb_xfer(1'b0, `JSP_REG_LCR, 8'h00, rd);
    end
    apb_write(`JSP_REG_LCR, 8'h80);
    apb_write(`JSP_REG_IER, 8'hff);
    apb_xfer(1'b0, `JSP_REG_IER, 8'h00, rd);
    apb_write(`JSP_REG_LCR, 8'h03);
    apb_write(`JSP_REG_IER, 8'hff);
    apb_xfer(1'b0, `JSP_REG_IER, 8'h00, rd);
    apb_write(`JSP_REG_IER, 8'h00);
    end_test("register readback");

    start_test();
    check_free(4'd8);
    repeat (8)
      debug_write(8'($urandom));
    check_free(4'd0);
    repeat (8)
    begin
      wait_lsr_bit(0, 1'b1);
      apb_xfer(1'b0, `JSP_REG_RBR, 8'h00, rd);
    end
    check_free(4'd8);
    end_test("debug to RBR");

    start_test();
    repeat (8)
    begin
      wait_lsr_bit(5, 1'b1);
      apb_write(`JSP_REG_RBR, 8'($urandom));
    end
    apb_xfer(1'b0, `JSP_REG_LSR, 8'h00, rd);
    repeat (8)
      debug_read();
    end_test("THR to debug");

    start_test();
    apb_write(`JSP_REG_IER, 8'h01);
    debug_write(8'($urandom));
    wait_lsr_bit(0, 1'b1);
    apb_xfer(1'b0, `JSP_REG_IIR, 8'h00, rd);
    apb_xfer(1'b0, `JSP_REG_RBR, 8'h00, rd);
    apb_write(`JSP_REG_IER, 8'h02);
    apb_write(`JSP_REG_RBR, 8'($urandom));
    apb_xfer(1'b0, `JSP_REG_IIR, 8'h00, rd);
    apb_xfer(1'b0, `JSP_REG_IIR, 8'h00, rd);
    apb_write(`JSP_REG_IER, 8'h00);
    end_test("interrupts");

    start_test();
    repeat (3)
      debug_write(8'($urandom));
    wait_lsr_bit(0, 1'b1);
    repeat (20) @(posedge tck_i);
    apb_write(`JSP_REG_IIR, 8'h02);
    apb_xfer(1'b0, `JSP_REG_LSR, 8'h00, rd);
    repeat (3)
      apb_write(`JSP_REG_RBR, 8'($urandom));
    wait (bytes_available != 0);
    apb_write(`JSP_REG_IIR, 8'h04);
    begin
      int waits;
      waits = 0;
      while (bytes_available != 0 && waits < 200)
      begin
        @(posedge tck_i);
        waits++;
      end
      if (bytes_available != 0)
        chk0.note_failure("bytes_available_o stayed nonzero after the TX clear");
    end
    end_test("FIFO clears");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_num, tests_failed, chk0.checks, chk0.errors);
    if (chk0.errors == 0 && tests_failed == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== jsp_apb_biu.f ====
+incdir+logic
logic/jsp_pkg.sv
logic/jsp_toggle_sync.sv
logic/jsp_count_sync.sv
logic/jsp_byte_fifo.sv
logic/jsp_jtag_port.sv
logic/jsp_xfer_fsm.sv
logic/jsp_apb_regs.sv
logic/jsp_apb_biu.sv
tests/jsp_checker.sv
tests/jsp_tb.sv
